// ==== include/bridge_params.svh ====
// bridge parameter macros for byte width, word width and buffer depth
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// width of one source byte
`define BRIDGE_BYTE_W 8

// width of one sink word, two bytes
`define BRIDGE_WORD_W 16

// default buffer depth in bytes
// must be even and at least 2, so a pair never straddles the wrap point
`define BRIDGE_FIFO_DEPTH 8

`endif

// ==== rtl/bridge_pkg.sv ====
// shared types for the byte-to-halfword bridge
package bridge_pkg;

    `include "bridge_params.svh"

    // two byte lanes of one output word
    typedef struct packed {
        logic [`BRIDGE_BYTE_W-1:0] hi;
        logic [`BRIDGE_BYTE_W-1:0] lo;
    } byte_lanes_t;

    // output word, seen as raw bits or as byte lanes
    typedef union packed {
        logic [`BRIDGE_WORD_W-1:0] raw;
        byte_lanes_t               lanes;
    } byte_pair_u;

    // write port into the converting buffer
    typedef struct packed {
        logic                      push;
        logic [`BRIDGE_BYTE_W-1:0] data;
    } fifo_wr_t;

    // fall-through view of the two oldest bytes
    typedef struct packed {
        logic       word_avail;
        byte_pair_u word;
    } fifo_rd_t;

endpackage

// ==== rtl/width_conv_fifo.sv ====
// width-converting ring buffer, one byte in per push and one byte pair out per pop
`timescale 1ns/1ps
`include "bridge_params.svh"

module width_conv_fifo
    import bridge_pkg::*;
#(
    parameter int DEPTH = `BRIDGE_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,
    input  fifo_wr_t wr,
    input  logic     pop,
    output logic     full,
    output fifo_rd_t rd
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // byte storage
    logic [`BRIDGE_BYTE_W-1:0] mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    // always even, so the pair never wraps
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    assign do_push = wr.push && !full;
    assign do_pop  = pop && rd.word_avail;

    assign full = (count == CNT_W'(DEPTH));

    // head pair, oldest byte in the low lane
    always_comb begin
        rd.word_avail     = (count >= CNT_W'(2));
        rd.word.lanes.lo  = mem[rd_ptr];
        rd.word.lanes.hi  = mem[rd_ptr + PTR_W'(1)];
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + PTR_W'(1);
                end
            end

            // read side steps by a whole pair
            if (do_pop) begin
                if (rd_ptr == PTR_W'(DEPTH - 2)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + PTR_W'(2);
                end
            end

            // one byte in, two bytes out
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(2);
                2'b11:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // ingress must hold off while the buffer is full
    property p_no_push_when_full;
        @(posedge clk) disable iff (!rst_n)
        wr.push |-> !full;
    endproperty

    assert property (p_no_push_when_full)
        else $error("push while buffer full");

    // egress only pops a complete pair
    property p_no_pop_without_pair;
        @(posedge clk) disable iff (!rst_n)
        pop |-> rd.word_avail;
    endproperty

    assert property (p_no_pop_without_pair)
        else $error("pop without a complete byte pair");

endmodule

// ==== rtl/byte_ingress.sv ====
// four-phase slave that takes source bytes and pushes them into the buffer
`timescale 1ns/1ps
`include "bridge_params.svh"

module byte_ingress
    import bridge_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_req,
    input  logic [`BRIDGE_BYTE_W-1:0] in_data,
    output logic                      in_ack,
    input  logic                      full,
    output fifo_wr_t                  wr
);

    // the two handshake states map directly onto in_ack
    // low  waiting for a new request
    // high acknowledged, waiting for req to drop
    logic accept;

    // new request, handshake idle and room in the buffer
    // a full buffer just postpones this cycle
    assign accept = in_req && !in_ack && !full;

    // exactly one write per handshake
    always_comb begin
        wr.push = accept;
        wr.data = in_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_ack <= 1'b0;
        end else begin
            if (accept) begin
                // byte stored at this edge, ack follows
                in_ack <= 1'b1;
            end else if (in_ack && !in_req) begin
                // source released, return to idle
                in_ack <= 1'b0;
            end
        end
    end

    // ack only ever answers a live request
    property p_ack_needs_req;
        @(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> in_req;
    endproperty

    assert property (p_ack_needs_req)
        else $error("in_ack rose without in_req");

endmodule

// ==== rtl/word_egress.sv ====
// four-phase master that pops byte pairs and offers them to the sink
`timescale 1ns/1ps

module word_egress
    import bridge_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  fifo_rd_t   rd,
    output logic       pop,
    output logic       out_req,
    output byte_pair_u out_data,
    input  logic       out_ack
);

    // handshake states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;
    localparam logic [1:0] ST_REL  = 2'd2;

    logic [1:0] state;

    // word being offered, frees the buffer slot right away
    byte_pair_u word_q;

    // take the head pair as soon as one is ready
    assign pop = (state == ST_IDLE) && rd.word_avail;

    assign out_req  = (state == ST_REQ);
    assign out_data = word_q;

    always_ff @(posedge clk) begin
        if (pop) begin
            word_q <= rd.word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rd.word_avail) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    // sink has it, drop req
                    if (out_ack) begin
                        state <= ST_REL;
                    end
                end
                ST_REL: begin
                    // wait for the sink to finish the cycle
                    if (!out_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // offered word holds for the whole request phase
    property p_data_stable;
        @(posedge clk) disable iff (!rst_n)
        out_req && $past(out_req) |-> $stable(out_data);
    endproperty

    assert property (p_data_stable)
        else $error("out_data changed while out_req high");

endmodule

// ==== rtl/byte_to_word_bridge.sv ====
// byte-to-halfword bridge, ingress slave, converting buffer and egress master
`timescale 1ns/1ps
`include "bridge_params.svh"

module byte_to_word_bridge
    import bridge_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    // byte source
    input  logic                      in_req,
    input  logic [`BRIDGE_BYTE_W-1:0] in_data,
    output logic                      in_ack,
    // word sink
    output logic                      out_req,
    output byte_pair_u                out_data,
    input  logic                      out_ack
);

    fifo_wr_t wr;
    fifo_rd_t rd;
    logic     full;
    logic     pop;

    byte_ingress u_ingress (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .in_data (in_data),
        .in_ack  (in_ack),
        .full    (full),
        .wr      (wr)
    );

    width_conv_fifo #(
        .DEPTH (`BRIDGE_FIFO_DEPTH)
    ) u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .pop   (pop),
        .full  (full),
        .rd    (rd)
    );

    word_egress u_egress (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd       (rd),
        .pop      (pop),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

endmodule

// ==== test/tb_bridge.sv ====
// testbench for the byte-to-halfword bridge, random source and sink checked against a byte queue
`timescale 1ns/1ps
`include "bridge_params.svh"

module tb_bridge
    import bridge_pkg::*;
();

    localparam int NUM_BYTES   = 400;
    localparam int NUM_WORDS   = NUM_BYTES / 2;
    localparam int STALL_WORD  = 60;
    localparam int STALL_LEN   = 40;
    localparam int ODD_WAIT    = 50;
    // buffer plus the word held by egress
    localparam int MAX_BACKLOG = `BRIDGE_FIFO_DEPTH + 2;
    localparam int WATCHDOG_NS = NUM_BYTES * 30 * 100;

    logic                      clk     = 1'b0;
    logic                      rst_n   = 1'b0;
    logic                      in_req  = 1'b0;
    logic [`BRIDGE_BYTE_W-1:0] in_data = '0;
    logic                      in_ack;
    logic                      out_req;
    byte_pair_u                out_data;
    logic                      out_ack = 1'b0;

    // reference model, bytes in acknowledge order
    logic [`BRIDGE_BYTE_W-1:0] model_q [$];

    int reset_edges  = 0;
    int bytes_target = 0;
    int bytes_sent   = 0;
    int words_done   = 0;
    int data_checks  = 0;
    int data_errors  = 0;
    int proto_errors = 0;
    int flow_errors  = 0;

    // samples from the previous edge
    logic       prev_rst_n   = 1'b0;
    logic       prev_in_req  = 1'b0;
    logic       prev_in_ack  = 1'b0;
    logic       prev_out_req = 1'b0;
    byte_pair_u prev_out_data;

    byte_to_word_bridge u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .out_ack  (out_ack)
    );

    always #50 clk = ~clk;

    // reset seen low by the first three rising edges
    always @(posedge clk) begin
        if (reset_edges < 3) begin
            reset_edges <= reset_edges + 1;
            if (reset_edges == 2) begin
                rst_n <= 1'b1;
            end
        end
    end

    // one full four-phase cycle on the source side
    task automatic send_byte(input logic [`BRIDGE_BYTE_W-1:0] value);
        in_req  <= 1'b1;
        in_data <= value;
        do begin
            @(posedge clk);
        end while (!in_ack);
        // byte now belongs to the bridge
        model_q.push_back(value);
        bytes_sent++;
        in_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (in_ack);
    endtask

    task automatic check_word(input byte_pair_u got);
        logic [`BRIDGE_WORD_W-1:0] expected;
        if (model_q.size() < 2) begin
            data_errors++;
            $display("Error at %0t ns: word offered before two bytes were acknowledged", $time);
        end else begin
            // first byte of a pair in the low lane
            expected = {model_q[1], model_q[0]};
            void'(model_q.pop_front());
            void'(model_q.pop_front());
            data_checks++;
            if (got.raw !== expected) begin
                data_errors++;
                $display("Error at %0t ns: out_data expected %h, got %h",
                         $time, expected, got.raw);
            end
        end
    endtask

    // source agent, 0 to 3 idle cycles between bytes
    always begin : source_agent
        int idle;
        @(posedge clk);
        if (rst_n && bytes_sent < bytes_target) begin
            send_byte(`BRIDGE_BYTE_W'($urandom));
            idle = $urandom_range(3, 0);
            repeat (idle) @(posedge clk);
        end
    end

    // sink agent, ack after 0 to 6 cycles, one long stall
    always begin : sink_agent
        int delay;
        @(posedge clk);
        if (out_req) begin
            check_word(out_data);
            if (words_done == STALL_WORD) begin
                delay = STALL_LEN;
            end else begin
                delay = $urandom_range(6, 0);
            end
            repeat (delay) @(posedge clk);
            out_ack <= 1'b1;
            words_done++;
            do begin
                @(posedge clk);
            end while (out_req);
            out_ack <= 1'b0;
        end
    end

    // protocol monitor
    always @(posedge clk) begin
        if (!rst_n || !prev_rst_n) begin
            if (in_ack !== 1'b0) begin
                proto_errors++;
                $display("Error at %0t ns: in_ack expected 0, got %b", $time, in_ack);
            end
            if (out_req !== 1'b0) begin
                proto_errors++;
                $display("Error at %0t ns: out_req expected 0, got %b", $time, out_req);
            end
        end else begin
            if (in_ack && !prev_in_ack && !prev_in_req) begin
                proto_errors++;
                $display("Error at %0t ns: in_ack rose while in_req was low", $time);
            end
            if (out_req && prev_out_req && out_data !== prev_out_data) begin
                proto_errors++;
                $display("Error at %0t ns: out_data expected %h, got %h",
                         $time, prev_out_data.raw, out_data.raw);
            end
            if (bytes_sent - 2 * words_done > MAX_BACKLOG) begin
                proto_errors++;
                $display("Error at %0t ns: %0d bytes acknowledged beyond delivered words, limit %0d",
                         $time, bytes_sent - 2 * words_done, MAX_BACKLOG);
            end
        end
        prev_rst_n    <= rst_n;
        prev_in_req   <= in_req;
        prev_in_ack   <= in_ack;
        prev_out_req  <= out_req;
        prev_out_data <= out_data;
    end

    initial begin
        void'($urandom(32'h470c_b367));
        bytes_target = NUM_BYTES;
        // wait for every pair and a quiet sink side
        do begin
            @(posedge clk);
        end while (words_done < NUM_WORDS || out_req || out_ack);
        // a lone trailing byte stays in the buffer
        bytes_target = NUM_BYTES + 1;
        do begin
            @(posedge clk);
        end while (bytes_sent < NUM_BYTES + 1);
        repeat (ODD_WAIT) begin
            @(posedge clk);
            if (out_req) begin
                flow_errors++;
                $display("Error at %0t ns: a word was offered for a single trailing byte", $time);
            end
        end
        if (words_done != NUM_WORDS) begin
            flow_errors++;
            $display("Error at %0t ns: expected %0d words, got %0d", $time, NUM_WORDS, words_done);
        end
        if (model_q.size() != 1) begin
            flow_errors++;
            $display("Error at %0t ns: expected 1 byte left in the model, got %0d",
                     $time, model_q.size());
        end
        $display("data checks %0d, data errors %0d, protocol errors %0d, flow errors %0d",
                 data_checks, data_errors, proto_errors, flow_errors);
        if (data_errors + proto_errors + flow_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the bridge stopped making progress", WATCHDOG_NS);
        $display("data checks %0d, data errors %0d, protocol errors %0d, flow errors %0d",
                 data_checks, data_errors, proto_errors, flow_errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
rtl/bridge_pkg.sv
rtl/width_conv_fifo.sv
rtl/byte_ingress.sv
rtl/word_egress.sv
rtl/byte_to_word_bridge.sv
test/tb_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the bridge testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_bridge -Mdir obj_dir -f project.f &&
./obj_dir/Vtb_bridge | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null &&
echo "run_sim: pass" ||
{ echo "run_sim: fail"; exit 1; }
